/* hdl/tcu_fmt_pkg.sv */
/*
 * Tensor core number formats.
 * Element and word typedefs, the format selector codes and the
 * field widths of fp16, fp8 E4M3 and fp32.
 */
package tcu_fmt_pkg;

    // operand format selector, same width as fmt_s
    typedef logic [3:0] fmt_code_t;

    localparam fmt_code_t FMT_FP16 = 4'd1;
    localparam fmt_code_t FMT_FP8  = 4'd3;  // E4M3

    typedef logic [31:0] word_t;  // one packed operand word
    typedef logic [15:0] fp16_t;
    typedef logic [7:0]  fp8_t;
    typedef logic [31:0] fp32_t;

    // fp16 fields
    localparam int FP16_EXP_W = 5;
    localparam int FP16_MAN_W = 10;
    localparam int FP16_BIAS  = 15;

    // fp8 E4M3 fields
    localparam int FP8_EXP_W = 4;
    localparam int FP8_MAN_W = 3;
    localparam int FP8_BIAS  = 7;

    // fp32 fields, used for c_val and d_val
    localparam int FP32_EXP_W = 8;
    localparam int FP32_MAN_W = 23;
    localparam int FP32_BIAS  = 127;

endpackage

/* hdl/tcu_acc_pkg.sv */
/*
 * Fixed-point accumulator definitions.
 * Window width, bus struct and stage latencies of the dot-product pipeline.
 */
package tcu_acc_pkg;

    localparam int ACC_W    = 96;
    localparam int ACC_FRAC = 48;  // lsb weight is 2^-48

    // signed two's complement fixed-point sum
    typedef logic signed [ACC_W-1:0] acc_t;

    // running product sum with its valid bit
    typedef struct packed {
        logic valid;
        acc_t sum;
    } acc_bus_t;

    // product register ahead of the adder tree
    localparam int MUL_LATENCY = 1;

    // sum + leading one, then rounded result
    localparam int NORM_LATENCY = 2;

endpackage

/* hdl/tcu_prod_path.sv */
/*
 * Product path of the dot-product unit.
 * Unpacks fp16 or fp8 elements, forms exact products in the fixed-point
 * window and reduces them in a registered binary adder tree.
 */
module tcu_prod_path #(
    parameter int N = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              enable,
    input  logic                              valid_in,
    input  tcu_fmt_pkg::fmt_code_t            fmt_s,
    input  tcu_fmt_pkg::word_t [N-1:0]        a_row,
    input  tcu_fmt_pkg::word_t [N-1:0]        b_col,
    output tcu_acc_pkg::acc_bus_t             prod_bus
);
    import tcu_fmt_pkg::*;
    import tcu_acc_pkg::*;

    localparam int P      = 4 * N;  // product slots, four per word
    localparam int LEVELS = $clog2(P);

    // window position of the product lsb, relative to both exponents
    localparam int SH16 = ACC_FRAC - 2 * (FP16_BIAS + FP16_MAN_W);
    localparam int SH8  = ACC_FRAC - 2 * (FP8_BIAS + FP8_MAN_W);

    // common element fields, wide enough for fp16
    typedef logic [FP16_EXP_W-1:0]     exp_t;
    typedef logic [FP16_MAN_W:0]       sig_t;
    typedef logic [2*FP16_MAN_W+1:0]   mag_t;

    acc_t prod_d [P];
    acc_t prod_q [P];
    logic prod_vld_q;

    // exact signed product placed in the window
    function automatic acc_t exact_term(logic neg, exp_t ea, exp_t eb,
                                        sig_t sa, sig_t sb, int base);
        exp_t xa;
        exp_t xb;
        mag_t mag;
        acc_t term;
        xa   = (ea == '0) ? exp_t'(1) : ea;  // subnormals share emin
        xb   = (eb == '0) ? exp_t'(1) : eb;
        mag  = mag_t'(sa) * mag_t'(sb);
        term = acc_t'(mag) << (int'(xa) + int'(xb) + base);
        return neg ? -term : term;
    endfunction

    function automatic acc_t fp16_prod(fp16_t a, fp16_t b);
        exp_t ea;
        exp_t eb;
        sig_t sa;
        sig_t sb;
        ea = a[FP16_MAN_W +: FP16_EXP_W];
        eb = b[FP16_MAN_W +: FP16_EXP_W];
        sa = {|ea, a[FP16_MAN_W-1:0]};  // hidden one only when normal
        sb = {|eb, b[FP16_MAN_W-1:0]};
        return exact_term(a[15] ^ b[15], ea, eb, sa, sb, SH16);
    endfunction

    function automatic acc_t fp8_prod(fp8_t a, fp8_t b);
        exp_t ea;
        exp_t eb;
        sig_t sa;
        sig_t sb;
        ea = exp_t'(a[FP8_MAN_W +: FP8_EXP_W]);
        eb = exp_t'(b[FP8_MAN_W +: FP8_EXP_W]);
        sa = sig_t'({|a[FP8_MAN_W +: FP8_EXP_W], a[FP8_MAN_W-1:0]});
        sb = sig_t'({|b[FP8_MAN_W +: FP8_EXP_W], b[FP8_MAN_W-1:0]});
        return exact_term(a[7] ^ b[7], ea, eb, sa, sb, SH8);
    endfunction

    // slot 4w+k holds element k of word w
    always_comb begin
        for (int w = 0; w < N; w++) begin
            for (int k = 0; k < 4; k++) begin
                prod_d[4*w+k] = '0;  // unused slots stay zero
            end
            case (fmt_s)
                FMT_FP16: begin
                    for (int k = 0; k < 2; k++) begin
                        prod_d[4*w+k] = fp16_prod(a_row[w][16*k +: 16],
                                                  b_col[w][16*k +: 16]);
                    end
                end
                FMT_FP8: begin
                    for (int k = 0; k < 4; k++) begin
                        prod_d[4*w+k] = fp8_prod(a_row[w][8*k +: 8],
                                                 b_col[w][8*k +: 8]);
                    end
                end
                default: ;  // unsupported code, products stay zero
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_vld_q <= 1'b0;
        end else if (enable) begin
            prod_vld_q <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            prod_q <= prod_d;
        end
    end

    // one register level per tree stage
    for (genvar l = 0; l < LEVELS; l++) begin : g_tree
        localparam int OUTSZ = P >> (l + 1);

        acc_t lvl_in [2*OUTSZ];
        logic lvl_vld;
        acc_t sum_q [OUTSZ];
        logic vld_q;

        if (l == 0) begin : g_src
            assign lvl_in  = prod_q;
            assign lvl_vld = prod_vld_q;
        end else begin : g_src
            assign lvl_in  = g_tree[l-1].sum_q;
            assign lvl_vld = g_tree[l-1].vld_q;
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                vld_q <= 1'b0;
            end else if (enable) begin
                vld_q <= lvl_vld;
            end
        end

        always_ff @(posedge clk) begin
            if (enable) begin
                for (int i = 0; i < OUTSZ; i++) begin
                    sum_q[i] <= lvl_in[2*i] + lvl_in[2*i+1];  // exact, no rounding
                end
            end
        end
    end

    assign prod_bus.valid = g_tree[LEVELS-1].vld_q;
    assign prod_bus.sum   = g_tree[LEVELS-1].sum_q[0];

endmodule

/* hdl/tcu_addend_path.sv */
/*
 * Addend path of the dot-product unit.
 * Converts the fp32 addend into the fixed-point window and delays it
 * to line up with the product sum.
 */
module tcu_addend_path #(
    parameter int N = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  tcu_fmt_pkg::fp32_t   c_val,
    output tcu_acc_pkg::acc_t    addend
);
    import tcu_fmt_pkg::*;
    import tcu_acc_pkg::*;

    localparam int P      = 4 * N;
    localparam int LEVELS = $clog2(P);
    localparam int ALIGN  = MUL_LATENCY + LEVELS;  // matches the product path

    // biased exponent whose significand lsb lands on 2^-48
    localparam int ZERO_SH = FP32_BIAS + FP32_MAN_W - ACC_FRAC;

    typedef logic [FP32_EXP_W-1:0] exp_t;
    typedef logic [FP32_MAN_W:0]   sig_t;

    exp_t c_exp;
    sig_t c_sig;
    acc_t c_mag;
    acc_t conv_d;
    acc_t pipe_q [ALIGN];

    always_comb begin
        c_exp = c_val[FP32_MAN_W +: FP32_EXP_W];
        c_sig = {|c_exp, c_val[FP32_MAN_W-1:0]};
        if (int'(c_exp) >= ZERO_SH) begin
            c_mag = acc_t'(c_sig) << (int'(c_exp) - ZERO_SH);
        end else begin
            // bits below 2^-48 fall off, subnormals vanish
            c_mag = acc_t'(c_sig) >> (ZERO_SH - int'(c_exp));
        end
        conv_d = c_val[FP32_EXP_W+FP32_MAN_W] ? -c_mag : c_mag;
    end

    // conversion register, then the delay line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ALIGN; i++) begin
                pipe_q[i] <= '0;
            end
        end else if (enable) begin
            pipe_q[0] <= conv_d;
            for (int i = 1; i < ALIGN; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign addend = pipe_q[ALIGN-1];

endmodule

/* hdl/tcu_norm_round.sv */
/*
 * Normalize and round stage.
 * Adds the addend to the product sum, finds the leading one and
 * rounds the magnitude to fp32 nearest-even.
 */
module tcu_norm_round (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  tcu_acc_pkg::acc_bus_t  prod_bus,
    input  tcu_acc_pkg::acc_t      addend,
    output logic                   valid_out,
    output tcu_fmt_pkg::fp32_t     d_val
);
    import tcu_fmt_pkg::*;
    import tcu_acc_pkg::*;

    // leading one at bit pos means 2^(pos - ACC_FRAC)
    localparam int EXP_OFS = FP32_BIAS - ACC_FRAC;

    typedef logic [ACC_W-1:0]         mag_t;
    typedef logic [$clog2(ACC_W)-1:0] pos_t;
    typedef logic [FP32_EXP_W-1:0]    exp_t;
    typedef logic [FP32_MAN_W-1:0]    man_t;

    acc_t total;
    logic neg_d;
    mag_t mag_d;
    pos_t pos_d;

    logic s1_vld;
    logic s1_neg;
    mag_t s1_mag;
    pos_t s1_pos;

    mag_t norm;
    man_t man;
    exp_t exp_d;
    logic guard;
    logic sticky;
    logic rnd_up;
    logic [FP32_EXP_W+FP32_MAN_W-1:0] body;
    fp32_t result_d;

    // stage one, sum and leading one
    always_comb begin
        total = prod_bus.sum + addend;
        neg_d = total[ACC_W-1];
        mag_d = neg_d ? mag_t'(-total) : mag_t'(total);
        pos_d = '0;
        for (int i = 0; i < ACC_W; i++) begin
            if (mag_d[i]) begin
                pos_d = pos_t'(i);  // highest set bit wins
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
        end else if (enable) begin
            s1_vld <= prod_bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            s1_neg <= neg_d;
            s1_mag <= mag_d;
            s1_pos <= pos_d;
        end
    end

    // stage two, align leading one to the msb and round
    always_comb begin
        norm   = s1_mag << (ACC_W - 1 - int'(s1_pos));
        man    = norm[ACC_W-2 -: FP32_MAN_W];
        guard  = norm[ACC_W-2-FP32_MAN_W];
        sticky = |norm[ACC_W-3-FP32_MAN_W:0];
        rnd_up = guard & (sticky | man[0]);  // ties go to even
        exp_d  = exp_t'(int'(s1_pos) + EXP_OFS);
        body   = {exp_d, man} + (FP32_EXP_W + FP32_MAN_W)'(rnd_up);  // carry bumps exp
        if (s1_mag == '0) begin
            result_d = '0;  // exact zero is +0
        end else begin
            result_d = {s1_neg, body};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (enable) begin
            valid_out <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            d_val <= result_d;
        end
    end

endmodule

/* hdl/tcu_fedp.sv */
/*
 * Fused dot-product unit, d_val = c_val + sum of a_i * b_i.
 * Product and addend paths run side by side into one rounding stage.
 */
module tcu_fedp #(
    parameter int N = 2  // operand words, power of two up to 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          enable,
    input  logic                          valid_in,
    input  tcu_fmt_pkg::fmt_code_t        fmt_s,
    input  tcu_fmt_pkg::word_t [N-1:0]    a_row,
    input  tcu_fmt_pkg::word_t [N-1:0]    b_col,
    input  tcu_fmt_pkg::fp32_t            c_val,
    output logic                          valid_out,
    output tcu_fmt_pkg::fp32_t            d_val
);
    import tcu_acc_pkg::*;

    acc_bus_t prod_bus;  // summed products with valid
    acc_t     addend;    // c_val in the same window

    tcu_prod_path #(
        .N (N)
    ) u_prod_path (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .valid_in (valid_in),
        .fmt_s    (fmt_s),
        .a_row    (a_row),
        .b_col    (b_col),
        .prod_bus (prod_bus)
    );

    tcu_addend_path #(
        .N (N)
    ) u_addend_path (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .c_val  (c_val),
        .addend (addend)
    );

    tcu_norm_round u_norm_round (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .prod_bus  (prod_bus),
        .addend    (addend),
        .valid_out (valid_out),
        .d_val     (d_val)
    );

endmodule

/* verification/tb_clock.sv */
/*
 * Testbench clock source, free running from time zero.
 */
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;  // half period per phase
        end
    end

endmodule

/* verification/tcu_fedp_model.svh */
/*
 * Reference model for the dot-product testbench.
 * Element decoders into fixed-point units, fp32 nearest-even rounding
 * and the Galois LFSR behind every random bit.
 */
`ifndef TCU_FEDP_MODEL_SVH
`define TCU_FEDP_MODEL_SVH

localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

logic [31:0] lfsr_state = 32'h60b5;

// one lfsr step per returned bit, first bit ends up as the msb
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return r;
endfunction

// fp16 element in units of 2^-24
function automatic logic signed [95:0] fp16_units(logic [15:0] h);
    logic signed [95:0] v;
    int e;
    e = int'(h[14:10]);
    v = {85'd0, h[14:10] != 5'd0, h[9:0]};
    v = v << ((e == 0) ? 0 : e - 1);  // subnormal scale equals exponent 1
    return h[15] ? -v : v;
endfunction

// fp8 E4M3 element, also in units of 2^-24
function automatic logic signed [95:0] fp8_units(logic [7:0] q);
    logic signed [95:0] v;
    int e;
    e = int'(q[6:3]);
    v = {92'd0, q[6:3] != 4'd0, q[2:0]};
    v = v << (((e == 0) ? 1 : e) + 14);
    return q[7] ? -v : v;
endfunction

// fp32 addend in units of 2^-48, low bits truncated
function automatic logic signed [95:0] c_units(logic [31:0] c);
    logic signed [95:0] v;
    int e;
    e = int'(c[30:23]);
    v = {72'd0, 1'b1, c[22:0]};
    if (e == 0) begin
        v = '0;
    end else if (e >= 102) begin
        v = v << (e - 102);
    end else begin
        v = v >> (102 - e);
    end
    return c[31] ? -v : v;
endfunction

function automatic logic [31:0] round_fp32(logic signed [95:0] s);
    logic [95:0] mag;
    logic [95:0] kept;
    logic [95:0] rest;
    logic [95:0] half;
    logic neg;
    int msb;
    int sh;
    logic [31:0] f;
    f = '0;  // exact zero stays +0
    if (s != 0) begin
        neg = s[95];
        mag = neg ? -s : s;
        msb = 0;
        for (int i = 0; i < 96; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        if (msb > 23) begin
            sh   = msb - 23;
            kept = mag >> sh;
            rest = mag & ((96'd1 << sh) - 96'd1);
            half = 96'd1 << (sh - 1);
            if (rest > half || (rest == half && kept[0])) begin
                kept = kept + 96'd1;
            end
            if (kept[24]) begin  // rounded up to the next binade
                kept = kept >> 1;
                msb  = msb + 1;
            end
        end else begin
            kept = mag << (23 - msb);
        end
        f = {neg, 8'(msb + 79), kept[22:0]};  // 2^(msb-48), bias 127
    end
    return f;
endfunction

// exact c + sum of products, rounded once
function automatic logic [31:0] model_dot(logic [3:0] fmt, logic [N*32-1:0] a,
                                          logic [N*32-1:0] b, logic [31:0] c);
    logic signed [95:0] acc;
    acc = c_units(c);
    for (int w = 0; w < N; w++) begin
        for (int k = 0; k < 4; k++) begin
            if (fmt == FMT_FP16 && k < 2) begin
                acc = acc + fp16_units(a[32*w+16*k +: 16]) * fp16_units(b[32*w+16*k +: 16]);
            end else if (fmt == FMT_FP8) begin
                acc = acc + fp8_units(a[32*w+8*k +: 8]) * fp8_units(b[32*w+8*k +: 8]);
            end
        end
    end
    return round_fp32(acc);
endfunction

`endif

/* verification/tcu_fedp_tb.sv */
/*
 * Testbench for the fused dot-product unit with N = 2.
 * Random fp16, fp8, cancellation, bad format and enable stall tests,
 * each result compared with the model in arrival order.
 */
module tcu_fedp_tb;
    import tcu_fmt_pkg::*;

    localparam int N            = 2;
    localparam int RST_CYCLES   = 10;
    localparam int ITEMS_RAND   = 150;  // fp16 and fp8 tests each
    localparam int ITEMS_CANCEL = 100;
    localparam int ITEMS_BADFMT = 60;
    localparam int ITEMS_STALL  = 200;
    // 660 items at 3/4 load plus stalls and drains come to about 1000 cycles
    localparam int MAX_CYCLES   = 4000;

    typedef logic [N*32-1:0] row_t;

    logic          clk;
    logic          rst_n;
    logic          enable;
    logic          valid_in;
    fmt_code_t     fmt_s;
    word_t [N-1:0] a_row;
    word_t [N-1:0] b_col;
    fp32_t         c_val;
    logic          valid_out;
    fp32_t         d_val;

    fp32_t exp_q [$];  // expected results in issue order
    fp32_t mon_exp;
    string cur_test;
    int    mon_errs = 0;
    int    seq_errs = 0;
    int    errs_at_start;
    int    n_tests = 0;
    int    n_accepted = 0;
    int    n_logged = 0;
    int    cycle_cnt = 0;

    `include "tcu_fedp_model.svh"

    tb_clock #(.PERIOD(100)) u_clock (.clk(clk));

    tcu_fedp #(.N(N)) u_tcu_fedp (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .valid_in  (valid_in),
        .fmt_s     (fmt_s),
        .a_row     (a_row),
        .b_col     (b_col),
        .c_val     (c_val),
        .valid_out (valid_out),
        .d_val     (d_val)
    );

    function automatic fp16_t rand_fp16();
        fp16_t h;
        h = fp16_t'(rand_bits(16));
        if (h[14:10] == 5'h1f) begin
            h[14:10] = 5'h1e;  // stay clear of inf and nan
        end
        return h;
    endfunction

    function automatic fp8_t rand_fp8();
        fp8_t q;
        q = fp8_t'(rand_bits(8));
        if (rand_bits(2) == 0) begin
            q[6:3] = 4'h0;  // more subnormals
        end
        if (q[6:0] == 7'h7f) begin
            q[6:0] = 7'h7e;  // E4M3 nan encoding
        end
        return q;
    endfunction

    function automatic row_t rand_row(fmt_code_t f);
        row_t r;
        for (int i = 0; i < 2 * N; i++) begin
            if (f == FMT_FP16) begin
                r[16*i +: 16] = rand_fp16();
            end else if (f == FMT_FP8) begin
                r[16*i +: 16] = {rand_fp8(), rand_fp8()};
            end else begin
                r[16*i +: 16] = 16'(rand_bits(16));
            end
        end
        return r;
    endfunction

    // nonzero addend, unbiased exponent within +-20
    function automatic fp32_t rand_c();
        logic s;
        int   e;
        s = rand_bits(1) != 0;
        e = 107 + int'(rand_bits(6) % 41);
        return {s, 8'(e), 23'(rand_bits(23))};
    endfunction

    // inputs change 5 units after the edge
    task automatic drive(logic en, logic vin, fmt_code_t f, row_t a, row_t b,
                         fp32_t c, fp32_t expv);
        @(posedge clk);
        #5;
        enable   = en;
        valid_in = vin;
        fmt_s    = f;
        a_row    = a;
        b_col    = b;
        c_val    = c;
        if (en && vin) begin
            exp_q.push_back(expv);
            n_accepted++;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            drive(1'b1, 1'b0, fmt_s, a_row, b_col, c_val, '0);
        end
        repeat (2) drive(1'b1, 1'b0, fmt_s, a_row, b_col, c_val, '0);
    endtask

    task automatic begin_test(string name);
        cur_test      = name;
        errs_at_start = mon_errs + seq_errs;
    endtask

    task automatic end_test(int items);
        drain();
        $display("test %s: %0d items, %0d errors", cur_test, items,
                 mon_errs + seq_errs - errs_at_start);
        n_tests++;
    endtask

    task automatic run_idle(int cycles);
        begin_test("idle_after_reset");
        for (int i = 0; i < cycles; i++) begin
            drive(1'b1, 1'b0, FMT_FP16, '0, '0, '0, '0);
            @(negedge clk);
            assert (valid_out == 1'b0) else begin
                $display("error in %s: valid_out high with no item sent", cur_test);
                seq_errs++;
            end
        end
        end_test(0);
    endtask

    // mode 0 fp16, 1 fp8, 2 mixed, 3 unsupported codes
    task automatic run_random(string name, int mode, int count, logic stall);
        int        done;
        logic      en;
        logic      vin;
        fmt_code_t f;
        row_t      a;
        row_t      b;
        fp32_t     c;
        fp32_t     expv;
        begin_test(name);
        done = 0;
        while (done < count) begin
            en  = stall ? (rand_bits(2) != 0) : 1'b1;
            vin = rand_bits(2) != 0;
            case (mode)
                0: f = FMT_FP16;
                1: f = FMT_FP8;
                2: f = (rand_bits(1) != 0) ? FMT_FP16 : FMT_FP8;
                default: begin
                    f = fmt_code_t'(rand_bits(4));
                    if (f == FMT_FP16 || f == FMT_FP8) begin
                        f = f + 4'd1;  // 2 or 4
                    end
                end
            endcase
            a    = rand_row(f);
            b    = rand_row(f);
            c    = rand_c();
            expv = (mode == 3) ? c : model_dot(f, a, b, c);  // no products, c passes
            drive(en, vin, f, a, b, c, expv);
            if (en && vin) begin
                done++;
            end
        end
        end_test(count);
    endtask

    // one product h * 1.0 against c = -h, odd items keep a small residue
    task automatic run_cancel(int count);
        fp16_t h;
        row_t  a;
        row_t  b;
        fp32_t c;
        fp32_t expv;
        begin_test("cancel");
        for (int i = 0; i < count; i++) begin
            h        = rand_fp16();
            h[14:10] = 5'(1 + rand_bits(5) % 30);  // normal only
            a        = '0;
            b        = '0;
            a[15:0]  = h;
            b[15:0]  = 16'h3c00;
            c        = {~h[15], 8'(int'(h[14:10]) + 112), h[9:0], 13'd0};
            if (i % 2 == 0) begin
                expv = 32'h0;  // exact cancel is +0
            end else begin
                c[12:0]   = 13'(rand_bits(13));
                a[47:32]  = rand_fp16();
                a[46:42]  = 5'(rand_bits(2));  // tiny second product
                b[47:32]  = rand_fp16();
                expv      = model_dot(FMT_FP16, a, b, c);
            end
            drive(1'b1, 1'b1, FMT_FP16, a, b, c, expv);
        end
        end_test(count);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (enable && valid_out) begin
            n_logged++;
            assert (exp_q.size() != 0) else begin
                $display("error in %s: result appeared with no item in flight", cur_test);
                mon_errs++;
            end
            if (exp_q.size() != 0) begin
                mon_exp = exp_q.pop_front();
                assert (d_val == mon_exp) else begin
                    $display("[FAIL] %s: expected %08h, actual %08h", cur_test, mon_exp, d_val);
                    mon_errs++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        rst_n    = 1'b0;
        enable   = 1'b1;
        valid_in = 1'b0;
        fmt_s    = FMT_FP16;
        a_row    = '0;
        b_col    = '0;
        c_val    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #5;
        rst_n = 1'b1;

        run_idle(20);
        run_random("fp16_random", 0, ITEMS_RAND, 1'b0);
        run_random("fp8_random", 1, ITEMS_RAND, 1'b0);
        run_cancel(ITEMS_CANCEL);
        run_random("bad_format", 3, ITEMS_BADFMT, 1'b0);
        run_random("enable_stall", 2, ITEMS_STALL, 1'b1);

        assert (n_logged == n_accepted && exp_q.size() == 0) else begin
            $display("error: %0d items accepted but %0d results returned", n_accepted, n_logged);
            seq_errs++;
        end
        $display("summary: %0d tests, %0d items, %0d errors", n_tests, n_accepted,
                 mon_errs + seq_errs);
        if (mon_errs + seq_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+verification
hdl/tcu_fmt_pkg.sv
hdl/tcu_acc_pkg.sv
hdl/tcu_prod_path.sv
hdl/tcu_addend_path.sv
hdl/tcu_norm_round.sv
hdl/tcu_fedp.sv
verification/tb_clock.sv
verification/tcu_fedp_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tcu_fedp testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module tcu_fedp_tb -f project.f -o tcu_fedp_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/tcu_fedp_sim); then
    echo "$out"
    echo "simulation exited with an error status"
    exit 1
fi
echo "$out"

# the pass line is printed only when no check failed
if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
